// ==== Bender.yml ====
package:
  name: uop_decode

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/isa_pkg.sv
      - source/decode_pkg.sv
      - source/uop_if.sv
      - source/uop_capture.sv
      - source/decode_oddball.sv
      - source/uop_classify.sv
      - source/decode_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_clock.sv
      - verif/decode_tb.sv

// ==== flist.f ====
+incdir+include
source/isa_pkg.sv
source/decode_pkg.sv
source/uop_if.sv
source/uop_capture.sv
source/decode_oddball.sv
source/uop_classify.sv
source/decode_top.sv
verif/tb_clock.sv
verif/decode_tb.sv

// ==== include/decode_cfg.svh ====
/* Decode path configuration */

`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// ==================================================
// Instruction format widths
// ==================================================

// One micro-op is a single instruction word
`define DECODE_INSTR_WIDTH 32

// Architectural register specifier width used by rd, rs1 and rs2
`define DECODE_REG_WIDTH 5

// Immediate field at the top of the instruction word
`define DECODE_IMM_WIDTH 10

// ==================================================
// Pipeline bookkeeping
// ==================================================

// Reorder tag width that travels with each micro-op
`define DECODE_TAG_WIDTH 4

`endif

// ==== source/decode_oddball.sv ====
/* ALU0-only instruction decoder */

`timescale 1ns/1ps
`default_nettype none

module decode_oddball (
	input  isa_pkg::micro_op_t uop,
	output logic               oddball
);

	// RTD subcodes in the low imm bits
	localparam logic [2:0] RTD_RTE  = 3'd1;
	localparam logic [2:0] RTD_ERET = 3'd2;

	// Ops that touch machine state must be serialized onto ALU #0
	// The other ALUs have no path to the CSR file or the trap logic
	always_comb
	begin
		case (uop.opcode)
			// Control and status register access
			isa_pkg::OP_CSR:
				oddball = 1'b1;
			// Breakpoint raises an exception
			isa_pkg::OP_BRK:
				oddball = 1'b1;
			// TRAP, REX and ECALL all sit under SYS
			isa_pkg::OP_SYS:
				oddball = 1'b1;
			// Plain RTD is an ordinary branch while RTE and ERET restore state
			isa_pkg::OP_RTD:
				oddball = (uop.imm[2:0] == RTD_RTE) || (uop.imm[2:0] == RTD_ERET);
			default:
				oddball = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/decode_pkg.sv ====
/* Decode result types */

`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

	// ==================================================
	// Functional unit selection
	// ==================================================

	// Illegal ops map to no unit at all
	// ALU0 is the only ALU that takes serializing ops
	typedef enum logic [2:0] {
		UNIT_NONE   = 3'd0,
		UNIT_ALU0   = 3'd1,
		UNIT_ALU    = 3'd2,
		UNIT_MEM    = 3'd3,
		UNIT_BRANCH = 3'd4
	} unit_t;

	// ==================================================
	// Classified micro-op
	// ==================================================

	// Everything the classify stage decides about one micro-op
	typedef struct packed {
		unit_t                        unit;
		logic                         oddball;
		logic                         illegal;
		logic                         writesReg;
		// Destination register is carried along unchanged
		logic [`DECODE_REG_WIDTH-1:0] rd;
	} classified_t;

endpackage

`default_nettype wire

// ==== source/decode_top.sv ====
/* Micro-op decode top */

`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decode_top (
	input  logic                           clk,
	input  logic                           rstN,
	// Incoming micro-op, one per cycle when inValid is high
	input  logic                           inValid,
	input  logic [`DECODE_INSTR_WIDTH-1:0] inInstr,
	input  logic [`DECODE_TAG_WIDTH-1:0]   inTag,
	// Classified micro-op, two cycles after it arrived
	output logic                           outValid,
	output logic [`DECODE_TAG_WIDTH-1:0]   outTag,
	output decode_pkg::unit_t              outUnit,
	output logic                           outOddball,
	output logic                           outIllegal,
	output logic                           outWritesReg,
	output logic [`DECODE_REG_WIDTH-1:0]   outRd
);

	// Bus between the capture and classify stages
	uop_if uop_i ();

	// ==================================================
	// Stage 1 captures and checks the opcode
	// ==================================================

	uop_capture capture_i (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.inInstr (inInstr),
		.inTag   (inTag),
		.out     (uop_i.producer)
	);

	// ==================================================
	// Stage 2 picks the unit and write-back
	// ==================================================

	uop_classify classify_i (
		.clk          (clk),
		.rstN         (rstN),
		.in           (uop_i.consumer),
		.outValid     (outValid),
		.outTag       (outTag),
		.outUnit      (outUnit),
		.outOddball   (outOddball),
		.outIllegal   (outIllegal),
		.outWritesReg (outWritesReg),
		.outRd        (outRd)
	);

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
/* Instruction set types */

`default_nettype none

`include "decode_cfg.svh"

package isa_pkg;

	// The opcode takes whatever the other fields leave of the word
	localparam int OPCODE_WIDTH =
		`DECODE_INSTR_WIDTH - `DECODE_IMM_WIDTH - 3 * `DECODE_REG_WIDTH;

	// ==================================================
	// Opcode encodings
	// ==================================================

	// Any code not listed here is an illegal instruction
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_NOP    = 7'h00,
		OP_BRK    = 7'h01,
		OP_SYS    = 7'h02,
		OP_ADD    = 7'h04,
		OP_SUB    = 7'h05,
		OP_CSR    = 7'h07,
		OP_AND    = 7'h08,
		OP_OR     = 7'h09,
		OP_BRANCH = 7'h20,
		// Return with deallocate whose imm subcode selects RTE or ERET
		OP_RTD    = 7'h22,
		OP_LOAD   = 7'h40,
		OP_STORE  = 7'h48
	} opcode_t;

	// ==================================================
	// Instruction word layout
	// ==================================================

	// Fields run from the top bit down to the opcode in bits 6:0
	typedef struct packed {
		logic [`DECODE_IMM_WIDTH-1:0] imm;
		logic [`DECODE_REG_WIDTH-1:0] rs2;
		logic [`DECODE_REG_WIDTH-1:0] rs1;
		logic [`DECODE_REG_WIDTH-1:0] rd;
		opcode_t                      opcode;
	} micro_op_t;

endpackage

`default_nettype wire

// ==== source/uop_capture.sv ====
/* Micro-op capture stage */

`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module uop_capture (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         inValid,
	input  isa_pkg::micro_op_t           inInstr,
	input  logic [`DECODE_TAG_WIDTH-1:0] inTag,
	uop_if.producer                      out
);

	logic opIllegal;

	// ==================================================
	// Opcode legality check
	// ==================================================

	// Only the listed encodings are real instructions
	always_comb
	begin
		case (inInstr.opcode)
			isa_pkg::OP_NOP, isa_pkg::OP_ADD, isa_pkg::OP_SUB,
			isa_pkg::OP_AND, isa_pkg::OP_OR, isa_pkg::OP_LOAD,
			isa_pkg::OP_STORE, isa_pkg::OP_BRANCH, isa_pkg::OP_CSR,
			isa_pkg::OP_BRK, isa_pkg::OP_RTD, isa_pkg::OP_SYS:
				opIllegal = 1'b0;
			default:
				opIllegal = 1'b1;
		endcase
	end

	// ==================================================
	// Stage registers
	// ==================================================

	// The strobe follows the input one cycle later
	always_ff @(posedge clk)
	begin
		if (!rstN)
			out.valid <= 1'b0;
		else
			out.valid <= inValid;
	end

	// Payload only loads on a valid input
	// Its content is ignored while valid is low
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			out.uop     <= inInstr;
			out.illegal <= opIllegal;
			out.tag     <= inTag;
		end
	end

endmodule

`default_nettype wire

// ==== source/uop_classify.sv ====
/* Micro-op classify stage */

`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module uop_classify (
	input  logic                         clk,
	input  logic                         rstN,
	uop_if.consumer                      in,
	output logic                         outValid,
	output logic [`DECODE_TAG_WIDTH-1:0] outTag,
	output decode_pkg::unit_t            outUnit,
	output logic                         outOddball,
	output logic                         outIllegal,
	output logic                         outWritesReg,
	output logic [`DECODE_REG_WIDTH-1:0] outRd
);

	logic                    isOddball;
	decode_pkg::classified_t cls;
	decode_pkg::classified_t clsQ;

	decode_oddball oddball_i (
		.uop     (in.uop),
		.oddball (isOddball)
	);

	// ==================================================
	// Unit and write-back selection
	// ==================================================

	always_comb
	begin
		// Defaults describe an illegal op
		cls.unit      = decode_pkg::UNIT_NONE;
		cls.oddball   = 1'b0;
		cls.illegal   = in.illegal;
		cls.writesReg = 1'b0;
		cls.rd        = in.uop.rd;
		if (!in.illegal)
		begin
			cls.oddball = isOddball;
			case (in.uop.opcode)
				// Register to register arithmetic and logic
				isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR:
				begin
					cls.unit      = decode_pkg::UNIT_ALU;
					cls.writesReg = (in.uop.rd != '0);
				end
				isa_pkg::OP_NOP:
					cls.unit = decode_pkg::UNIT_ALU;
				isa_pkg::OP_LOAD:
				begin
					cls.unit      = decode_pkg::UNIT_MEM;
					cls.writesReg = (in.uop.rd != '0);
				end
				isa_pkg::OP_STORE:
					cls.unit = decode_pkg::UNIT_MEM;
				// RTD lands here unless the oddball override below takes it
				isa_pkg::OP_BRANCH, isa_pkg::OP_RTD:
					cls.unit = decode_pkg::UNIT_BRANCH;
				// CSR reads return the old value into rd
				isa_pkg::OP_CSR:
					cls.writesReg = (in.uop.rd != '0);
				default:
					cls.unit = decode_pkg::UNIT_NONE;
			endcase
			// Serializing ops always go to ALU #0
			if (isOddball)
				cls.unit = decode_pkg::UNIT_ALU0;
		end
	end

	// ==================================================
	// Output registers
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else
			outValid <= in.valid;
	end

	always_ff @(posedge clk)
	begin
		if (in.valid)
		begin
			clsQ   <= cls;
			outTag <= in.tag;
		end
	end

	// Registered result fans out to the flat ports
	assign outUnit      = clsQ.unit;
	assign outOddball   = clsQ.oddball;
	assign outIllegal   = clsQ.illegal;
	assign outWritesReg = clsQ.writesReg;
	assign outRd        = clsQ.rd;

endmodule

`default_nettype wire

// ==== source/uop_if.sv ====
/* Captured micro-op bus */

`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

interface uop_if;

	// One-cycle strobe per captured micro-op with no ready in return
	logic                         valid;
	isa_pkg::micro_op_t           uop;
	// Opcode matched no defined instruction
	logic                         illegal;
	logic [`DECODE_TAG_WIDTH-1:0] tag;

	// Capture stage drives everything
	modport producer (output valid, output uop, output illegal, output tag);

	// Classify stage only reads
	modport consumer (input valid, input uop, input illegal, input tag);

endinterface

`default_nettype wire

// ==== verif/decode_tb.sv ====
/* Decode path testbench */

`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decode_tb;

	localparam int RESET_CYCLES   = 5;
	localparam int TIMEOUT_CYCLES = 20;
	localparam int BURST_LEN      = 16;

	logic                           clk;
	logic                           rstN;
	logic                           inValid;
	logic [`DECODE_INSTR_WIDTH-1:0] inInstr;
	logic [`DECODE_TAG_WIDTH-1:0]   inTag;
	logic                           outValid;
	logic [`DECODE_TAG_WIDTH-1:0]   outTag;
	decode_pkg::unit_t              outUnit;
	logic                           outOddball;
	logic                           outIllegal;
	logic                           outWritesReg;
	logic [`DECODE_REG_WIDTH-1:0]   outRd;

	int errorCount;
	int timeoutCount;

	// Every opcode the instruction set defines
	// Any other code is illegal
	isa_pkg::opcode_t legalOps [12] = '{
		isa_pkg::OP_NOP, isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
		isa_pkg::OP_OR, isa_pkg::OP_LOAD, isa_pkg::OP_STORE, isa_pkg::OP_BRANCH,
		isa_pkg::OP_CSR, isa_pkg::OP_BRK, isa_pkg::OP_RTD, isa_pkg::OP_SYS
	};

	tb_clock clock_i (
		.clk (clk)
	);

	decode_top dut_i (
		.clk          (clk),
		.rstN         (rstN),
		.inValid      (inValid),
		.inInstr      (inInstr),
		.inTag        (inTag),
		.outValid     (outValid),
		.outTag       (outTag),
		.outUnit      (outUnit),
		.outOddball   (outOddball),
		.outIllegal   (outIllegal),
		.outWritesReg (outWritesReg),
		.outRd        (outRd)
	);

	// ==================================================
	// Expectation model
	// ==================================================

	function automatic bit isDefinedOpcode(input logic [isa_pkg::OPCODE_WIDTH-1:0] code);
		for (int k = 0; k < 12; k++)
			if (code == legalOps[k])
				return 1'b1;
		return 1'b0;
	endfunction

	// Builds the result straight from the classification rules
	function automatic decode_pkg::classified_t expectedClass(input isa_pkg::micro_op_t op);
		decode_pkg::classified_t exp;
		isa_pkg::opcode_t opc;
		opc           = op.opcode;
		exp.rd        = op.rd;
		exp.illegal   = !isDefinedOpcode(op.opcode);
		exp.unit      = decode_pkg::UNIT_NONE;
		exp.oddball   = 1'b0;
		exp.writesReg = 1'b0;
		if (!exp.illegal)
		begin
			// RTE is subcode 1 and ERET is subcode 2
			exp.oddball = (opc == isa_pkg::OP_CSR) || (opc == isa_pkg::OP_BRK) ||
				(opc == isa_pkg::OP_SYS) ||
				(opc == isa_pkg::OP_RTD && (op.imm[2:0] == 3'd1 || op.imm[2:0] == 3'd2));
			if (exp.oddball)
				exp.unit = decode_pkg::UNIT_ALU0;
			else if (opc == isa_pkg::OP_LOAD || opc == isa_pkg::OP_STORE)
				exp.unit = decode_pkg::UNIT_MEM;
			else if (opc == isa_pkg::OP_BRANCH || opc == isa_pkg::OP_RTD)
				exp.unit = decode_pkg::UNIT_BRANCH;
			else
				exp.unit = decode_pkg::UNIT_ALU;
			exp.writesReg = (op.rd != 0) && (opc == isa_pkg::OP_ADD ||
				opc == isa_pkg::OP_SUB || opc == isa_pkg::OP_AND ||
				opc == isa_pkg::OP_OR || opc == isa_pkg::OP_LOAD || opc == isa_pkg::OP_CSR);
		end
		return exp;
	endfunction

	// Random fields around a chosen opcode
	function automatic isa_pkg::micro_op_t randomOp(input isa_pkg::opcode_t opc);
		isa_pkg::micro_op_t op;
		op        = isa_pkg::micro_op_t'($urandom());
		op.opcode = opc;
		return op;
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic checkUnit(input string name, input decode_pkg::unit_t expected,
		input decode_pkg::unit_t actual);
		if (actual !== expected)
		begin
			$display("FAIL t=%0t %s expected %s(%0d) actual %s(%0d)", $time, name,
				expected.name(), expected, actual.name(), actual);
			errorCount++;
		end
	endtask

	task automatic checkBits(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	// Compares every output field against one expected micro-op
	task automatic checkResult(input decode_pkg::classified_t exp,
		input logic [`DECODE_TAG_WIDTH-1:0] tag);
		checkUnit("outUnit", exp.unit, outUnit);
		checkBits("outOddball", exp.oddball, outOddball);
		checkBits("outIllegal", exp.illegal, outIllegal);
		checkBits("outWritesReg", exp.writesReg, outWritesReg);
		checkBits("outRd", exp.rd, outRd);
		checkBits("outTag", tag, outTag);
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	// One micro-op alone in the pipe, output expected two cycles later
	task automatic sendAndCheck(input string testName, input isa_pkg::micro_op_t op);
		decode_pkg::classified_t exp;
		logic [`DECODE_TAG_WIDTH-1:0] tag;
		int waited;
		exp = expectedClass(op);
		tag = $urandom_range(15);
		@(negedge clk);
		inValid = 1'b1;
		inInstr = op;
		inTag   = tag;
		@(negedge clk);
		inValid = 1'b0;
		waited  = 1;
		while (!outValid && waited < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		if (!outValid)
		begin
			$display("Timeout in %s, no output appeared for the micro-op", testName);
			timeoutCount++;
		end
		else
		begin
			checkBits("latency", 2, waited);
			checkResult(exp, tag);
		end
	endtask

	task automatic testReset();
		rstN = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			@(negedge clk);
			checkBits("outValid", 0, outValid);
		end
		rstN = 1'b1;
		// Nothing was sent, so the pipe must stay empty
		repeat (2)
		begin
			@(negedge clk);
			checkBits("outValid", 0, outValid);
		end
	endtask

	task automatic testOddball();
		isa_pkg::micro_op_t op;
		sendAndCheck("testOddball", randomOp(isa_pkg::OP_CSR));
		sendAndCheck("testOddball", randomOp(isa_pkg::OP_BRK));
		sendAndCheck("testOddball", randomOp(isa_pkg::OP_SYS));
		// RTD subcodes 1 and 2 serialize while 0 and 3 stay plain branches
		for (int sub = 0; sub < 4; sub++)
		begin
			op          = randomOp(isa_pkg::OP_RTD);
			op.imm[2:0] = sub[2:0];
			sendAndCheck("testOddball", op);
		end
	endtask

	task automatic testUnits();
		isa_pkg::micro_op_t op;
		for (int k = 0; k < 12; k++)
		begin
			op = randomOp(legalOps[k]);
			op.rd = $urandom_range(31, 1);
			sendAndCheck("testUnits", op);
			// A zero destination never writes back
			op.rd = '0;
			sendAndCheck("testUnits", op);
		end
	endtask

	task automatic testIllegal();
		isa_pkg::micro_op_t op;
		logic [isa_pkg::OPCODE_WIDTH-1:0] code;
		for (int n = 0; n < 12; n++)
		begin
			code = $urandom_range(127);
			// Walk up from the random pick to the next undefined code
			for (int k = 0; k < 128 && isDefinedOpcode(code); k++)
				code = code + 1'b1;
			op        = isa_pkg::micro_op_t'($urandom());
			op.opcode = isa_pkg::opcode_t'(code);
			sendAndCheck("testIllegal", op);
		end
	endtask

	// Inputs go in every cycle while results are checked as they leave
	task automatic testPipeline();
		decode_pkg::classified_t expQ[$];
		logic [`DECODE_TAG_WIDTH-1:0] tagQ[$];
		int issueQ[$];
		decode_pkg::classified_t exp;
		isa_pkg::micro_op_t op;
		logic [`DECODE_TAG_WIDTH-1:0] tag;
		logic [`DECODE_TAG_WIDTH-1:0] base;
		int cycle;
		int sent;
		int received;
		base     = $urandom_range(15);
		cycle    = 0;
		sent     = 0;
		received = 0;
		while (received < BURST_LEN && cycle < BURST_LEN + TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			// Outputs have been stable since the last rising edge
			if (outValid)
			begin
				if (expQ.size() == 0)
				begin
					$display("Output appeared at t=%0t with no micro-op outstanding", $time);
					errorCount++;
				end
				else
				begin
					exp = expQ.pop_front();
					tag = tagQ.pop_front();
					checkBits("latency", 2, cycle - issueQ.pop_front());
					checkResult(exp, tag);
					received++;
				end
			end
			else if (received > 0)
			begin
				$display("Burst output stream has a gap at t=%0t", $time);
				errorCount++;
			end
			if (sent < BURST_LEN)
			begin
				op  = randomOp(legalOps[$urandom_range(11)]);
				tag = base + sent[`DECODE_TAG_WIDTH-1:0];
				inValid = 1'b1;
				inInstr = op;
				inTag   = tag;
				expQ.push_back(expectedClass(op));
				tagQ.push_back(tag);
				issueQ.push_back(cycle);
				sent++;
			end
			else
				inValid = 1'b0;
			cycle++;
		end
		inValid = 1'b0;
		if (received < BURST_LEN)
		begin
			$display("Timeout in testPipeline, only %0d of %0d results arrived",
				received, BURST_LEN);
			timeoutCount++;
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial
	begin
		rstN         = 1'b0;
		inValid      = 1'b0;
		inInstr      = '0;
		inTag        = '0;
		errorCount   = 0;
		timeoutCount = 0;
		// One seed for the whole run
		void'($urandom(16));
		testReset();
		testOddball();
		testUnits();
		testIllegal();
		testPipeline();
		@(negedge clk);
		$display("Summary: %0d check errors, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
/* Testbench clock */

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	// Half of the 100 ns period
	localparam time HALF_PERIOD = 50ns;

	// Starts low so the first rising edge lands at 50 ns
	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_PERIOD) clk = ~clk;
	end

endmodule

`default_nettype wire
